/* hw/cache_pkg.sv */
package cache_pkg;

    // Geometry of the cache and its two ports
    localparam int ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH   = 32;
    localparam int BE_WIDTH     = DATA_WIDTH / 8;
    localparam int NUM_WAYS     = 2;
    localparam int NUM_SETS     = 8;
    localparam int INDEX_WIDTH  = 3;
    localparam int OFFSET_WIDTH = 2;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // Width of each statistics counter
    localparam int COUNT_WIDTH  = 32;

    // One line holds one word, so the offset only selects a byte inside it
    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } cache_addr_fields_t;

    // The memory port sees the raw word, the lookup sees the fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] word;
        cache_addr_fields_t    fields;
    } cache_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT_RESP,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        RESP
    } ctrl_state_t;

endpackage

/* hw/cache_store.sv */
`timescale 1ns/1ps

module cache_store (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                lookup_i,
    input  cache_pkg::cache_addr_t              lookup_addr_i,

    input  logic                                write_i,
    input  logic                                write_way_i,
    input  logic [cache_pkg::BE_WIDTH-1:0]      write_be_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    write_data_i,
    input  logic                                write_dirty_i,

    input  logic                                touch_i,
    input  logic                                touch_way_i,

    output logic                                hit_o,
    output logic                                hit_way_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    rdata_o,
    output logic                                victim_way_o,
    output logic                                victim_dirty_o,
    output logic [cache_pkg::TAG_WIDTH-1:0]     victim_tag_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    victim_data_o
);

    import cache_pkg::*;

    logic [TAG_WIDTH-1:0]   tag_mem  [NUM_WAYS][NUM_SETS];
    logic [DATA_WIDTH-1:0]  data_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0]    valid_q  [NUM_SETS];
    logic [NUM_WAYS-1:0]    dirty_q  [NUM_SETS];
    // Holds the most recently used way of each set
    logic [NUM_SETS-1:0]    mru_q;

    logic [INDEX_WIDTH-1:0] idx;
    logic [NUM_WAYS-1:0]    way_hit;
    logic                   vict_way;

    assign idx = lookup_addr_i.fields.index;

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_hit[w] = valid_q[idx][w] && (tag_mem[w][idx] == lookup_addr_i.fields.tag);
        end
    end

    // An empty way is filled first, otherwise the way not used last is evicted
    always_comb
    begin
        if (!valid_q[idx][0])
            vict_way = 1'b0;
        else if (!valid_q[idx][1])
            vict_way = 1'b1;
        else
            vict_way = ~mru_q[idx];
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hit_o          <= 1'b0;
            hit_way_o      <= 1'b0;
            victim_way_o   <= 1'b0;
            victim_dirty_o <= 1'b0;
        end
        else if (lookup_i)
        begin
            hit_o          <= |way_hit;
            hit_way_o      <= way_hit[1];
            victim_way_o   <= vict_way;
            victim_dirty_o <= valid_q[idx][vict_way] && dirty_q[idx][vict_way];
        end
    end

    // Results stay stable until the next lookup, the controller relies on that
    always_ff @(posedge clk)
    begin
        if (lookup_i)
        begin
            rdata_o       <= data_mem[way_hit[1]][idx];
            victim_tag_o  <= tag_mem[vict_way][idx];
            victim_data_o <= data_mem[vict_way][idx];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            mru_q <= '0;
        end
        else
        begin
            if (write_i)
            begin
                valid_q[idx][write_way_i] <= 1'b1;
                dirty_q[idx][write_way_i] <= write_dirty_i;
            end
            if (touch_i)
                mru_q[idx] <= touch_way_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (write_i)
        begin
            tag_mem[write_way_i][idx] <= lookup_addr_i.fields.tag;
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (write_be_i[b])
                    data_mem[write_way_i][idx][8*b +: 8] <= write_data_i[8*b +: 8];
            end
        end
    end

endmodule

/* hw/cache_counters.sv */
`timescale 1ns/1ps

module cache_counters (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                hit_i,
    input  logic                                miss_i,
    input  logic                                mem_txn_i,
    output logic [cache_pkg::COUNT_WIDTH-1:0]   hit_count_o,
    output logic [cache_pkg::COUNT_WIDTH-1:0]   miss_count_o,
    output logic [cache_pkg::COUNT_WIDTH-1:0]   mem_txn_count_o
);

    import cache_pkg::*;

    logic [2:0]             inc;
    logic [COUNT_WIDTH-1:0] count_q [3];

    assign inc = {mem_txn_i, miss_i, hit_i};

    // Each counter sticks at its maximum instead of wrapping
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 3; i++)
            begin
                count_q[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < 3; i++)
            begin
                if (inc[i] && count_q[i] != '1)
                    count_q[i] <= count_q[i] + 1'b1;
            end
        end
    end

    assign hit_count_o     = count_q[0];
    assign miss_count_o    = count_q[1];
    assign mem_txn_count_o = count_q[2];

endmodule

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                proc_req_i,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]    proc_addr_i,
    input  logic                                proc_we_i,
    input  logic [cache_pkg::BE_WIDTH-1:0]      proc_be_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    proc_wdata_i,
    output logic                                proc_gnt_o,
    output logic                                proc_rvalid_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    proc_rdata_o,

    output logic                                mem_req_o,
    output logic [cache_pkg::ADDR_WIDTH-1:0]    mem_addr_o,
    output logic                                mem_we_o,
    output logic [cache_pkg::BE_WIDTH-1:0]      mem_be_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    mem_wdata_o,
    input  logic                                mem_gnt_i,
    input  logic                                mem_rvalid_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    mem_rdata_i,

    output logic                                lookup_o,
    output cache_pkg::cache_addr_t              lookup_addr_o,
    output logic                                write_o,
    output logic                                write_way_o,
    output logic [cache_pkg::BE_WIDTH-1:0]      write_be_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    write_data_o,
    output logic                                write_dirty_o,
    output logic                                touch_o,
    output logic                                touch_way_o,

    input  logic                                hit_i,
    input  logic                                hit_way_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    rdata_i,
    input  logic                                victim_way_i,
    input  logic                                victim_dirty_i,
    input  logic [cache_pkg::TAG_WIDTH-1:0]     victim_tag_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    victim_data_i,

    output logic                                hit_o,
    output logic                                miss_o,
    output logic                                mem_txn_o
);

    import cache_pkg::*;

    ctrl_state_t            state;
    cache_addr_t            addr_q;
    logic                   we_q;
    logic [BE_WIDTH-1:0]    be_q;
    logic [DATA_WIDTH-1:0]  wdata_q;

    cache_addr_t            fill_addr;
    cache_addr_t            wb_addr;
    logic [DATA_WIDTH-1:0]  merged;

    // The lookup is issued straight from IDLE so the result is ready in LOOKUP
    assign lookup_o = (state == IDLE) && proc_req_i;

    always_comb
    begin
        if (state == IDLE)
            lookup_addr_o.word = proc_addr_i;
        else
            lookup_addr_o = addr_q;
    end

    always_comb
    begin
        fill_addr                = addr_q;
        fill_addr.fields.offset  = '0;
        wb_addr.fields.tag       = victim_tag_i;
        wb_addr.fields.index     = addr_q.fields.index;
        wb_addr.fields.offset    = '0;
    end

    // Store miss: stored bytes win over the fetched word
    always_comb
    begin
        for (int b = 0; b < BE_WIDTH; b++)
        begin
            if (we_q && be_q[b])
                merged[8*b +: 8] = wdata_q[8*b +: 8];
            else
                merged[8*b +: 8] = mem_rdata_i[8*b +: 8];
        end
    end

    always_comb
    begin
        write_o       = 1'b0;
        touch_o       = 1'b0;
        write_way_o   = victim_way_i;
        write_be_o    = '1;
        write_data_o  = merged;
        write_dirty_o = we_q;
        if (state == LOOKUP && hit_i)
        begin
            touch_o       = 1'b1;
            write_o       = we_q;
            write_way_o   = hit_way_i;
            write_be_o    = be_q;
            write_data_o  = wdata_q;
            write_dirty_o = 1'b1;
        end
        else if (state == FILL_WAIT && mem_rvalid_i)
        begin
            write_o = 1'b1;
            touch_o = 1'b1;
        end
    end

    assign touch_way_o = write_way_o;
    assign proc_gnt_o  = (state == HIT_RESP) || (state == RESP);
    assign mem_be_o    = '1;
    assign hit_o       = (state == LOOKUP) && hit_i;
    assign miss_o      = (state == LOOKUP) && !hit_i;
    assign mem_txn_o   = mem_req_o && mem_gnt_i;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state         <= IDLE;
            mem_req_o     <= 1'b0;
            proc_rvalid_o <= 1'b0;
        end
        else
        begin
            proc_rvalid_o <= 1'b0;
            unique case (state)
                IDLE:
                begin
                    if (proc_req_i)
                        state <= LOOKUP;
                end
                LOOKUP:
                begin
                    if (hit_i)
                        state <= HIT_RESP;
                    else
                    begin
                        mem_req_o <= 1'b1;
                        state     <= victim_dirty_i ? WB_REQ : FILL_REQ;
                    end
                end
                HIT_RESP, RESP:
                begin
                    proc_rvalid_o <= 1'b1;
                    state         <= IDLE;
                end
                WB_REQ:
                begin
                    if (mem_gnt_i)
                    begin
                        mem_req_o <= 1'b0;
                        state     <= WB_WAIT;
                    end
                end
                WB_WAIT:
                begin
                    if (mem_rvalid_i)
                    begin
                        mem_req_o <= 1'b1;
                        state     <= FILL_REQ;
                    end
                end
                FILL_REQ:
                begin
                    if (mem_gnt_i)
                    begin
                        mem_req_o <= 1'b0;
                        state     <= FILL_WAIT;
                    end
                end
                FILL_WAIT:
                begin
                    if (mem_rvalid_i)
                        state <= RESP;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && proc_req_i)
        begin
            addr_q.word <= proc_addr_i;
            we_q        <= proc_we_i;
            be_q        <= proc_be_i;
            wdata_q     <= proc_wdata_i;
        end
        if (state == LOOKUP && !hit_i)
        begin
            mem_addr_o  <= victim_dirty_i ? wb_addr.word : fill_addr.word;
            mem_we_o    <= victim_dirty_i;
            mem_wdata_o <= victim_data_i;
        end
        if (state == WB_WAIT && mem_rvalid_i)
        begin
            mem_addr_o <= fill_addr.word;
            mem_we_o   <= 1'b0;
        end
        // A store always answers with zero data
        if (state == FILL_WAIT && mem_rvalid_i)
            proc_rdata_o <= we_q ? '0 : mem_rdata_i;
        if (state == HIT_RESP)
            proc_rdata_o <= we_q ? '0 : rdata_i;
    end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                proc_req_i,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]    proc_addr_i,
    input  logic                                proc_we_i,
    input  logic [cache_pkg::BE_WIDTH-1:0]      proc_be_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    proc_wdata_i,
    output logic                                proc_gnt_o,
    output logic                                proc_rvalid_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    proc_rdata_o,

    output logic                                mem_req_o,
    output logic [cache_pkg::ADDR_WIDTH-1:0]    mem_addr_o,
    output logic                                mem_we_o,
    output logic [cache_pkg::BE_WIDTH-1:0]      mem_be_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    mem_wdata_o,
    input  logic                                mem_gnt_i,
    input  logic                                mem_rvalid_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    mem_rdata_i,

    output logic [cache_pkg::COUNT_WIDTH-1:0]   hit_count_o,
    output logic [cache_pkg::COUNT_WIDTH-1:0]   miss_count_o,
    output logic [cache_pkg::COUNT_WIDTH-1:0]   mem_txn_count_o
);

    import cache_pkg::*;

    logic                   lookup;
    cache_addr_t            lookup_addr;
    logic                   write;
    logic                   write_way;
    logic [BE_WIDTH-1:0]    write_be;
    logic [DATA_WIDTH-1:0]  write_data;
    logic                   write_dirty;
    logic                   touch;
    logic                   touch_way;
    logic                   hit;
    logic                   hit_way;
    logic [DATA_WIDTH-1:0]  rdata;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [TAG_WIDTH-1:0]   victim_tag;
    logic [DATA_WIDTH-1:0]  victim_data;
    logic                   hit_evt;
    logic                   miss_evt;
    logic                   mem_txn_evt;

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .proc_req_i     (proc_req_i),
        .proc_addr_i    (proc_addr_i),
        .proc_we_i      (proc_we_i),
        .proc_be_i      (proc_be_i),
        .proc_wdata_i   (proc_wdata_i),
        .proc_gnt_o     (proc_gnt_o),
        .proc_rvalid_o  (proc_rvalid_o),
        .proc_rdata_o   (proc_rdata_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_we_o       (mem_we_o),
        .mem_be_o       (mem_be_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_gnt_i      (mem_gnt_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .lookup_o       (lookup),
        .lookup_addr_o  (lookup_addr),
        .write_o        (write),
        .write_way_o    (write_way),
        .write_be_o     (write_be),
        .write_data_o   (write_data),
        .write_dirty_o  (write_dirty),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .rdata_i        (rdata),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_data_i  (victim_data),
        .hit_o          (hit_evt),
        .miss_o         (miss_evt),
        .mem_txn_o      (mem_txn_evt)
    );

    cache_store u_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_i       (lookup),
        .lookup_addr_i  (lookup_addr),
        .write_i        (write),
        .write_way_i    (write_way),
        .write_be_i     (write_be),
        .write_data_i   (write_data),
        .write_dirty_i  (write_dirty),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .rdata_o        (rdata),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_data_o  (victim_data)
    );

    cache_counters u_counters (
        .clk             (clk),
        .rst_n           (rst_n),
        .hit_i           (hit_evt),
        .miss_i          (miss_evt),
        .mem_txn_i       (mem_txn_evt),
        .hit_count_o     (hit_count_o),
        .miss_count_o    (miss_count_o),
        .mem_txn_count_o (mem_txn_count_o)
    );

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset is released just after the fourth rising edge
    initial
    begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* bench/cache_asserts.sv */
`timescale 1ns/1ps

module cache_asserts (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::ctrl_state_t  state_i,
    input  logic                    proc_gnt_i,
    input  logic                    proc_rvalid_i,
    input  logic                    mem_req_i,
    input  logic                    mem_gnt_i
);

    import cache_pkg::*;

    gnt_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        proc_gnt_i |=> !proc_gnt_i)
        else $error("Processor grant lasted longer than one cycle");

    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_i && !mem_gnt_i |=> mem_req_i)
        else $error("Memory request dropped before its grant");

    rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        proc_gnt_i |=> proc_rvalid_i)
        else $error("Processor rvalid did not follow the grant");

    mem_req_in_req_state: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_i |-> (state_i == WB_REQ || state_i == FILL_REQ))
        else $error("Memory request outside a request state");

endmodule

bind cache_ctrl cache_asserts u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .state_i       (state),
    .proc_gnt_i    (proc_gnt_o),
    .proc_rvalid_i (proc_rvalid_o),
    .mem_req_i     (mem_req_o),
    .mem_gnt_i     (mem_gnt_i)
);

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    import cache_pkg::*;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   proc_req_i;
    logic [ADDR_WIDTH-1:0]  proc_addr_i;
    logic                   proc_we_i;
    logic [BE_WIDTH-1:0]    proc_be_i;
    logic [DATA_WIDTH-1:0]  proc_wdata_i;
    logic                   proc_gnt_o;
    logic                   proc_rvalid_o;
    logic [DATA_WIDTH-1:0]  proc_rdata_o;
    logic                   mem_req_o;
    logic [ADDR_WIDTH-1:0]  mem_addr_o;
    logic                   mem_we_o;
    logic [BE_WIDTH-1:0]    mem_be_o;
    logic [DATA_WIDTH-1:0]  mem_wdata_o;
    logic                   mem_gnt_i;
    logic                   mem_rvalid_i;
    logic [DATA_WIDTH-1:0]  mem_rdata_i;
    logic [COUNT_WIDTH-1:0] hit_count_o;
    logic [COUNT_WIDTH-1:0] miss_count_o;
    logic [COUNT_WIDTH-1:0] mem_txn_count_o;

    // Words written back by the cache, keyed by byte address
    logic [DATA_WIDTH-1:0]  mem_store [int];
    int                     mem_phase;
    int                     mem_delay;
    logic [ADDR_WIDTH-1:0]  mem_addr_q;
    logic                   mem_we_q;

    clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    cache_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .proc_req_i      (proc_req_i),
        .proc_addr_i     (proc_addr_i),
        .proc_we_i       (proc_we_i),
        .proc_be_i       (proc_be_i),
        .proc_wdata_i    (proc_wdata_i),
        .proc_gnt_o      (proc_gnt_o),
        .proc_rvalid_o   (proc_rvalid_o),
        .proc_rdata_o    (proc_rdata_o),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_we_o        (mem_we_o),
        .mem_be_o        (mem_be_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_gnt_i       (mem_gnt_i),
        .mem_rvalid_i    (mem_rvalid_i),
        .mem_rdata_i     (mem_rdata_i),
        .hit_count_o     (hit_count_o),
        .miss_count_o    (miss_count_o),
        .mem_txn_count_o (mem_txn_count_o)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_count(input logic [COUNT_WIDTH-1:0] got,
                               input logic [COUNT_WIDTH-1:0] exp, input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // Untouched memory holds the address in the upper half and its inverse below
    function automatic logic [DATA_WIDTH-1:0] mem_pattern(input logic [ADDR_WIDTH-1:0] addr);
        return {addr, ~addr};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] mem_read(input logic [ADDR_WIDTH-1:0] addr);
        if (mem_store.exists(int'(addr)))
            return mem_store[int'(addr)];
        return mem_pattern(addr);
    endfunction

    // Memory model, grant and rvalid each come 1 to 3 cycles late
    initial
    begin
        void'($urandom(72));
        forever
        begin
            @(posedge clk);
            #1;
            mem_gnt_i    = 1'b0;
            mem_rvalid_i = 1'b0;
            if (rst_n)
            begin
                case (mem_phase)
                    0:
                    begin
                        if (mem_req_o)
                        begin
                            mem_delay = $urandom_range(1, 3);
                            mem_phase = 1;
                        end
                    end
                    1:
                    begin
                        mem_delay--;
                        if (mem_delay == 0)
                        begin
                            check_flag(mem_be_o == '1, 1'b1, "memory byte enables all set");
                            mem_gnt_i  = 1'b1;
                            mem_addr_q = mem_addr_o;
                            mem_we_q   = mem_we_o;
                            if (mem_we_o)
                                mem_store[int'(mem_addr_o)] = mem_wdata_o;
                            mem_delay = $urandom_range(1, 3);
                            mem_phase = 2;
                        end
                    end
                    default:
                    begin
                        mem_delay--;
                        if (mem_delay == 0)
                        begin
                            mem_rvalid_i = 1'b1;
                            mem_rdata_i  = mem_we_q ? '0 : mem_read(mem_addr_q);
                            mem_phase    = 0;
                        end
                    end
                endcase
            end
        end
    end

    task automatic run_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [BE_WIDTH-1:0] be, input logic [DATA_WIDTH-1:0] wdata,
                              output logic [DATA_WIDTH-1:0] rdata,
                              output int gnt_cyc, output int rv_cyc);
        int cyc;
        cyc          = 0;
        proc_req_i   = 1'b1;
        proc_we_i    = we;
        proc_addr_i  = addr;
        proc_be_i    = be;
        proc_wdata_i = wdata;
        do
        begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc > TIMEOUT)
                stop_run($sformatf("Timeout at %0t ns while waiting for the grant", $time));
        end
        while (!proc_gnt_o);
        gnt_cyc      = cyc;
        proc_req_i   = 1'b0;
        proc_we_i    = 1'b0;
        proc_be_i    = '0;
        proc_wdata_i = '0;
        do
        begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc > TIMEOUT)
                stop_run($sformatf("Timeout at %0t ns while waiting for rvalid", $time));
        end
        while (!proc_rvalid_o);
        rv_cyc = cyc;
        rdata  = proc_rdata_o;
    endtask

    initial
    begin
        int                    fd;
        int                    n;
        int                    cyc;
        int                    gnt_cyc;
        int                    rv_cyc;
        int                    flag;
        int                    exp_hits;
        int                    exp_misses;
        int                    exp_txns;
        string                 line;
        logic [7:0]            op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [BE_WIDTH-1:0]   be;
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] exp_data;
        logic [DATA_WIDTH-1:0] rdata;

        proc_req_i   = 1'b0;
        proc_addr_i  = '0;
        proc_we_i    = 1'b0;
        proc_be_i    = '0;
        proc_wdata_i = '0;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_phase    = 0;
        mem_delay    = 0;
        exp_hits     = 0;
        exp_misses   = 0;
        exp_txns     = 0;

        cyc = 0;
        while (rst_n !== 1'b1)
        begin
            @(posedge clk);
            cyc++;
            if (cyc > TIMEOUT)
                stop_run("Reset was never released");
        end
        @(posedge clk);
        #1;
        check_flag(proc_gnt_o, 1'b0, "proc_gnt_o after reset");
        check_flag(proc_rvalid_o, 1'b0, "proc_rvalid_o after reset");
        check_flag(mem_req_o, 1'b0, "mem_req_o after reset");
        check_count(hit_count_o, '0, "hit count after reset");
        check_count(miss_count_o, '0, "miss count after reset");
        check_count(mem_txn_count_o, '0, "memory transaction count after reset");

        fd = $fopen("bench/cache_stim.txt", "r");
        if (fd == 0)
            stop_run("Could not open the stimulus file bench/cache_stim.txt");
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%c %h %h %h %h %d", op, addr, be, wdata, exp_data, flag);
            if (n != 6)
                stop_run($sformatf("Badly formed stimulus line: %s", line));
            if (op == "M")
            begin
                check_word(mem_read(addr), exp_data, $sformatf("memory word %h", addr));
                continue;
            end
            run_access(op == "S", addr, be, wdata, rdata, gnt_cyc, rv_cyc);
            check_word(rdata, exp_data, $sformatf("read data of %c %h", op, addr));
            check_flag(gnt_cyc == 2, flag == 1, $sformatf("hit of %c %h", op, addr));
            if (flag == 1)
            begin
                check_count(rv_cyc, 3, "hit rvalid latency");
                exp_hits++;
            end
            else
            begin
                check_flag(rv_cyc > 3, 1'b1, "miss latency above hit latency");
                exp_misses++;
                // A dirty victim costs a write-back before the refill
                exp_txns += (flag == 2) ? 2 : 1;
            end
        end
        $fclose(fd);

        @(posedge clk);
        #1;
        check_count(hit_count_o, exp_hits, "hit count");
        check_count(miss_count_o, exp_misses, "miss count");
        check_count(mem_txn_count_o, exp_txns, "memory transaction count");

        $display("All tests passed");
        $finish;
    end

endmodule

/* bench/cache_stim.txt */
# op addr be wdata expected_rdata flag   (op L load, S store, M memory check)
# flag 1 hit, 0 miss, 2 miss with dirty write-back
L 0004 0 00000000 0004fffb 0
L 0004 0 00000000 0004fffb 1
S 0008 3 11223344 00000000 0
L 0008 0 00000000 00083344 1
S 0008 8 aa000000 00000000 1
L 0008 0 00000000 aa083344 1
L 0028 0 00000000 0028ffd7 0
L 0048 0 00000000 0048ffb7 2
M 0008 0 00000000 aa083344 0
L 0008 0 00000000 aa083344 0
L 0048 0 00000000 0048ffb7 1
S 000c f deadbeef 00000000 0
L 000c 0 00000000 deadbeef 1
S 0004 2 00005a00 00000000 1
L 0004 0 00000000 00045afb 1
L 0024 0 00000000 0024ffdb 0
L 0044 0 00000000 0044ffbb 2
M 0004 0 00000000 00045afb 0
L 0004 0 00000000 00045afb 0
S 002c 1 00000077 00000000 0
S 004c 1 00000077 00000000 2
M 000c 0 00000000 deadbeef 0
L 004c 0 00000000 004cff77 1
L 002c 0 00000000 002cff77 1

/* tb.f */
hw/cache_pkg.sv
hw/cache_store.sv
hw/cache_counters.sv
hw/cache_ctrl.sv
hw/cache_top.sv
bench/clk_gen.sv
bench/cache_asserts.sv
bench/tb_top.sv

/* Makefile */
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert --top-module tb_top -f tb.f --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

lint:
	verilator --lint-only --timing --top-module tb_top -f tb.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
